// ==== sources.f ====
common/cluster_pkg.sv
common/link_pkg.sv
logic/cluster_capture.sv
link_tx/link_reset_seq.sv
link_tx/link_frame_builder.sv
logic/trigger_links.sv
tests/trigger_links_checker.sv
tests/tb_trigger_links.sv

// ==== Bender.yml ====
package:
  name: trigger_links

sources:
  # packages first, the RTL modules import them
  - files:
      - common/cluster_pkg.sv
      - common/link_pkg.sv

  - files:
      - logic/cluster_capture.sv
      - link_tx/link_reset_seq.sv
      - link_tx/link_frame_builder.sv
      - logic/trigger_links.sv

  - target: test
    files:
      - tests/trigger_links_checker.sv
      - tests/tb_trigger_links.sv

// ==== tests/tb_trigger_links.sv ====
module tb_trigger_links;
  timeunit 1ns;
  timeprecision 1ps;

  import cluster_pkg::*;
  import link_pkg::*;

  typedef struct packed {
    int           cyc;    // cycle the flags show up
    cluster_vec_t flags;
  } valid_exp_t;

  typedef struct packed {
    int             cyc;  // cycle of word 0
    link_word_vec_t w0;
    link_word_vec_t w1;
  } frame_exp_t;

  logic                      clk_80;
  logic                      reset;
  cluster_t [N_CLUSTERS-1:0] clusters;
  bxn_t                      bxn;
  logic                      bc0;
  logic                      overflow;
  logic                      bx_strobe;
  cluster_vec_t              valid_clusters;
  logic                      valid_or;
  logic                      link_ready;
  link_word_vec_t            tx_word;
  logic                      tx_first;

  logic [31:0]  lcg_state = 32'h18954040;
  int           cyc = 0;          // counted on falling edges
  int           rst_low_cyc = -1;  // first cycle with reset low
  cluster_vec_t exp_valid = '0;
  valid_exp_t   valid_q[$];
  frame_exp_t   frame_q[$];

  trigger_links dut0 (
    .clk_80           (clk_80),
    .reset            (reset),
    .clusters_i       (clusters),
    .bxn_i            (bxn),
    .bc0_i            (bc0),
    .overflow_i       (overflow),
    .bx_strobe_i      (bx_strobe),
    .valid_clusters_o (valid_clusters),
    .valid_or_o       (valid_or),
    .link_ready_o     (link_ready),
    .tx_word_o        (tx_word),
    .tx_first_o       (tx_first)
  );

  bind trigger_links trigger_links_checker checker0 (
    .clk_80           (clk_80),
    .reset            (reset),
    .valid_clusters_i (valid_clusters_o),
    .valid_or_i       (valid_or_o),
    .link_ready_i     (link_ready_o),
    .tx_word_i        (tx_word_o),
    .tx_first_i       (tx_first_o)
  );

  initial begin
    clk_80 = 1'b0;
    forever #20 clk_80 = ~clk_80;
  end

  // ----------------------------------------
  // random source and reference rules
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // about one in four slots empty
  function automatic cluster_t rand_cluster();
    logic [31:0] r;
    cluster_t    c;
    r = next_rand();
    c = r[29:16];
    if (r[31:30] == 2'b00) begin
      c[10:9] = 2'b11;
    end else if (c[10:9] == 2'b11) begin
      c[10] = 1'b0;
    end
    return c;
  endfunction

  function automatic marker_t expected_marker(logic bc0_v, logic ovf_v, bxn_t bxn_v);
    marker_t m;
    m = MARK_DATA;
    if (bxn_v[6:0] == 7'd0) m = MARK_LAT;
    if (ovf_v) m = MARK_OVF;
    if (bc0_v) m = MARK_BC0;  // strongest rule applied last
    return m;
  endfunction

  function automatic logic ready_expected(int c);
    return rst_low_cyc >= 0 && c >= rst_low_cyc + RESET_HOLD + 1;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic fail_run(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_valid(cluster_vec_t got, cluster_vec_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED valid_clusters_o got 0x%02h expected 0x%02h (cycle %0d)",
                         got, exp, cyc));
    end
  endtask

  task automatic check_word(int link, link_word_t got, link_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED tx_word_o[%0d] got 0x%08h expected 0x%08h (cycle %0d)",
                         link, got, exp, cyc));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED %s got 0x%0h expected 0x%0h (cycle %0d)",
                         name, got, exp, cyc));
    end
  endtask

  // ----------------------------------------
  // output monitor, every cycle
  // ----------------------------------------
  initial begin : monitor
    link_word_vec_t exp_w;
    logic           exp_first;
    @(posedge clk_80);  // outputs defined after the first reset edge
    forever begin
      @(negedge clk_80);
      cyc++;
      if (!reset && rst_low_cyc < 0) begin
        rst_low_cyc = cyc;
      end
      if (valid_q.size() > 0 && valid_q[0].cyc == cyc) begin
        exp_valid = valid_q[0].flags;
        void'(valid_q.pop_front());
      end
      exp_w     = {N_LINKS{IDLE_WORD}};  // filler unless a frame is due
      exp_first = 1'b0;
      if (frame_q.size() > 0) begin
        if (frame_q[0].cyc == cyc) begin
          exp_w     = frame_q[0].w0;
          exp_first = 1'b1;
        end else if (frame_q[0].cyc + 1 == cyc) begin
          exp_w = frame_q[0].w1;
          void'(frame_q.pop_front());
        end
      end
      check_valid(valid_clusters, exp_valid);
      check_flag("valid_or_o", valid_or, |exp_valid);
      check_flag("link_ready_o", link_ready, ready_expected(cyc));
      check_flag("tx_first_o", tx_first, exp_first);
      for (int i = 0; i < N_LINKS; i++) begin
        check_word(i, tx_word[i], exp_w[i]);
      end
    end
  end

  // ----------------------------------------
  // one bx with strobe, quiet cycle and gap
  // ----------------------------------------
  task automatic send_bx(bxn_t bxn_v, logic bc0_v, logic ovf_v, int gap);
    cluster_t [N_CLUSTERS-1:0] cl;
    cluster_vec_t              flags;
    link_data_t                right;
    link_data_t                left;
    marker_t                   mark;
    frame_exp_t                fr;
    int                        s;
    for (int i = 0; i < N_CLUSTERS; i++) begin
      cl[i]    = rand_cluster();
      flags[i] = !(cl[i][10] && cl[i][9]);
    end
    right = {cl[3], cl[2], cl[1], cl[0]};
    left  = {cl[7], cl[6], cl[5], cl[4]};
    mark  = expected_marker(bc0_v, ovf_v, bxn_v);
    @(posedge clk_80);
    s = cyc;
    clusters  <= cl;
    bxn       <= bxn_v;
    bc0       <= bc0_v;
    overflow  <= ovf_v;
    bx_strobe <= 1'b1;
    valid_q.push_back('{cyc: s + 2, flags: flags});
    if (ready_expected(s + 2)) begin  // builders see ready on cap_valid
      fr.cyc = s + 3;
      for (int i = 0; i < N_LINKS; i++) begin
        fr.w0[i] = {mark, (i % 2 == 0) ? right[55:32] : left[55:32]};
        fr.w1[i] = (i % 2 == 0) ? right[31:0] : left[31:0];
      end
      frame_q.push_back(fr);
    end
    @(posedge clk_80);
    bx_strobe <= 1'b0;
    for (int i = 0; i < N_CLUSTERS; i++) begin
      cl[i] = rand_cluster();  // junk between strobes
    end
    clusters <= cl;
    repeat (gap) @(posedge clk_80);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    int          n;
    clusters  = '0;
    bxn       = '0;
    bc0       = 1'b0;
    overflow  = 1'b0;
    bx_strobe = 1'b0;
    reset     = 1'b1;
    repeat (10) @(posedge clk_80);
    reset <= 1'b0;

    // these land before link ready and give flags only
    for (int i = 0; i < 3; i++) begin
      send_bx(bxn_t'(i + 1), 1'b0, 1'b0, 1);
    end
    n = 0;
    while (!link_ready && n < 4 * RESET_HOLD) begin
      @(posedge clk_80);
      n++;
    end
    if (!link_ready) begin
      fail_run("link_ready_o never rose after reset");
    end

    // directed marker cases
    send_bx(12'h123, 1'b1, 1'b1, 1);  // bc0 beats overflow
    send_bx(12'h045, 1'b0, 1'b1, 2);
    send_bx(12'h100, 1'b0, 1'b1, 0);  // overflow beats latency mark
    send_bx(12'h000, 1'b1, 1'b0, 0);
    send_bx(12'h080, 1'b0, 1'b0, 0);
    send_bx(12'hF80, 1'b0, 1'b0, 3);
    send_bx(12'h081, 1'b0, 1'b0, 0);
    send_bx(12'h7FF, 1'b0, 1'b0, 1);

    for (int b = 0; b < 600; b++) begin
      r = next_rand();
      send_bx(r[31:20], r[19:15] == 5'd0, r[14:11] == 4'd0, int'(r[10:9]));
    end

    n = 0;
    while ((frame_q.size() > 0 || valid_q.size() > 0) && n < 10) begin
      @(posedge clk_80);
      n++;
    end
    if (frame_q.size() == 0 && valid_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run("expected frames still pending after the last bx");
    end
  end

endmodule

// ==== tests/trigger_links_checker.sv ====
module trigger_links_checker (
  input logic                      clk_80,
  input logic                      reset,
  input cluster_pkg::cluster_vec_t valid_clusters_i,
  input logic                      valid_or_i,
  input logic                      link_ready_i,
  input link_pkg::link_word_vec_t  tx_word_i,
  input logic                      tx_first_i
);
  timeunit 1ns;
  timeprecision 1ps;

  import link_pkg::*;

  // ----------------------------------------
  // link start-up and framing
  // ----------------------------------------
  first_after_ready: assert property (
    @(posedge clk_80) disable iff (reset) !link_ready_i |-> !tx_first_i
  ) else $error("frame started before the links were ready");

  // a frame is two words, so no two starts in a row
  no_double_first: assert property (
    @(posedge clk_80) disable iff (reset) tx_first_i |=> !tx_first_i
  ) else $error("frame start on two consecutive cycles");

  valid_or_match: assert property (
    @(posedge clk_80) disable iff (reset) valid_or_i == |valid_clusters_i
  ) else $error("valid_or does not match the valid flags");

  // outside a frame every link carries filler
  idle_between_frames: assert property (
    @(posedge clk_80) disable iff (reset)
      (!tx_first_i && !$past(tx_first_i)) |-> tx_word_i == {N_LINKS{IDLE_WORD}}
  ) else $error("non-idle word outside a frame");

endmodule

// ==== logic/trigger_links.sv ====
module trigger_links (
  input  logic                                                clk_80,
  input  logic                                                reset,
  input  cluster_pkg::cluster_t [cluster_pkg::N_CLUSTERS-1:0] clusters_i,
  input  cluster_pkg::bxn_t                                   bxn_i,
  input  logic                                                bc0_i,
  input  logic                                                overflow_i,
  input  logic                                                bx_strobe_i,
  output cluster_pkg::cluster_vec_t                           valid_clusters_o,
  output logic                                                valid_or_o,
  output logic                                                link_ready_o,
  output link_pkg::link_word_vec_t                            tx_word_o,
  output logic                                                tx_first_o
);
  import cluster_pkg::*;
  import link_pkg::*;

  capture_t           cap;
  logic               cap_valid;
  logic               ready;
  link_data_t         payload_r;   // clusters 3..0
  link_data_t         payload_l;   // clusters 7..4
  logic [N_LINKS-1:0] link_first;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  cluster_capture capture0 (
    .clk_80           (clk_80),
    .reset            (reset),
    .clusters_i       (clusters_i),
    .bxn_i            (bxn_i),
    .bc0_i            (bc0_i),
    .overflow_i       (overflow_i),
    .bx_strobe_i      (bx_strobe_i),
    .capture_o        (cap),
    .cap_valid_o      (cap_valid),
    .valid_clusters_o (valid_clusters_o),
    .valid_or_o       (valid_or_o)
  );

  assign payload_r = cap.clusters[3:0];
  assign payload_l = cap.clusters[7:4];

  link_reset_seq rstseq0 (
    .clk_80  (clk_80),
    .reset   (reset),
    .ready_o (ready)
  );

  assign link_ready_o = ready;

  // ----------------------------------------
  // links 0/2 right, 1/3 left
  // ----------------------------------------
  for (genvar i = 0; i < N_LINKS; i++) begin : link_gen
    link_data_t data;
    assign data = (i % 2 == 0) ? payload_r : payload_l;

    link_frame_builder builder (
      .clk_80  (clk_80),
      .reset   (reset),
      .data_i  (data),
      .bx_i    (cap.bx),
      .load_i  (cap_valid),
      .ready_i (ready),
      .word_o  (tx_word_o[i]),
      .first_o (link_first[i])
    );
  end

  // builders run in lockstep
  assign tx_first_o = &link_first;

endmodule

// ==== link_tx/link_frame_builder.sv ====
module link_frame_builder (
  input  logic                  clk_80,
  input  logic                  reset,
  input  link_pkg::link_data_t  data_i,
  input  cluster_pkg::bx_info_t bx_i,
  input  logic                  load_i,
  input  logic                  ready_i,
  output link_pkg::link_word_t  word_o,
  output logic                  first_o
);
  import cluster_pkg::*;
  import link_pkg::*;

  typedef enum logic {
    IDLE,
    SECOND
  } state_t;

  state_t     state;
  link_word_t word1_q;  // payload low half for the second word
  logic       start;    // new frame this cycle

  // ----------------------------------------
  // marker choice
  // ----------------------------------------
  // bc0 wins over overflow, overflow over the latency mark
  function automatic marker_t pick_marker(bx_info_t bx);
    if (bx.bc0) begin
      return MARK_BC0;
    end else if (bx.overflow) begin
      return MARK_OVF;
    end else if (bx.bxn[6:0] == 7'd0) begin
      return MARK_LAT;
    end
    return MARK_DATA;
  endfunction

  // links stay quiet until the reset sequencer lets go
  assign start = load_i && ready_i && (state == IDLE);

  // ----------------------------------------
  // second word store
  // ----------------------------------------
  always_ff @(posedge clk_80) begin
    if (start) begin
      word1_q <= data_i[31:0];
    end
  end

  // ----------------------------------------
  // frame FSM
  // ----------------------------------------
  always_ff @(posedge clk_80) begin
    if (reset) begin
      state   <= IDLE;
      word_o  <= IDLE_WORD;
      first_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            word_o  <= {pick_marker(bx_i), data_i[55:32]};  // word 0
            first_o <= 1'b1;
            state   <= SECOND;
          end else begin
            word_o  <= IDLE_WORD;
            first_o <= 1'b0;
          end
        end
        SECOND: begin
          word_o  <= word1_q;  // word 1
          first_o <= 1'b0;
          state   <= IDLE;  // next load may follow right away
        end
        default: begin
          word_o  <= IDLE_WORD;
          first_o <= 1'b0;
          state   <= IDLE;
        end
      endcase
    end
  end

endmodule

// ==== link_tx/link_reset_seq.sv ====
module link_reset_seq (
  input  logic clk_80,
  input  logic reset,
  output logic ready_o
);
  import link_pkg::*;

  rst_cnt_t hold_cnt;  // counts idle cycles since reset

  // ----------------------------------------
  // hold counter
  // ----------------------------------------
  // saturates at RESET_HOLD and ready follows one cycle later
  always_ff @(posedge clk_80) begin
    if (reset) begin
      hold_cnt <= '0;
      ready_o  <= 1'b0;
    end else begin
      if (hold_cnt != rst_cnt_t'(RESET_HOLD)) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
      ready_o <= (hold_cnt == rst_cnt_t'(RESET_HOLD));  // stays high once reached
    end
  end

endmodule

// ==== logic/cluster_capture.sv ====
module cluster_capture (
  input  logic                                                clk_80,
  input  logic                                                reset,
  input  cluster_pkg::cluster_t [cluster_pkg::N_CLUSTERS-1:0] clusters_i,
  input  cluster_pkg::bxn_t                                   bxn_i,
  input  logic                                                bc0_i,
  input  logic                                                overflow_i,
  input  logic                                                bx_strobe_i,
  output cluster_pkg::capture_t                               capture_o,
  output logic                                                cap_valid_o,
  output cluster_pkg::cluster_vec_t                           valid_clusters_o,
  output logic                                                valid_or_o
);
  import cluster_pkg::*;

  cluster_vec_t valid_next;  // flags of the words on the inputs now

  // ----------------------------------------
  // per-cluster valid test
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < N_CLUSTERS; i++) begin
      valid_next[i] = cluster_valid(clusters_i[i]);
    end
  end

  // ----------------------------------------
  // payload capture
  // ----------------------------------------
  // held between strobes for the builders
  always_ff @(posedge clk_80) begin
    if (bx_strobe_i) begin
      capture_o.clusters <= clusters_i;
      capture_o.bx       <= '{bxn: bxn_i, bc0: bc0_i, overflow: overflow_i};
    end
  end

  // ----------------------------------------
  // strobe delay and flags
  // ----------------------------------------
  always_ff @(posedge clk_80) begin
    if (reset) begin
      cap_valid_o      <= 1'b0;
      valid_clusters_o <= '0;
    end else begin
      cap_valid_o <= bx_strobe_i;  // one pulse per bx
      if (bx_strobe_i) begin
        valid_clusters_o <= valid_next;
      end
    end
  end

  // any cluster in this bx
  assign valid_or_o = |valid_clusters_o;

endmodule

// ==== common/link_pkg.sv ====
package link_pkg;

  // ----------------------------------------
  // link geometry
  // ----------------------------------------
  localparam int N_LINKS = 4;  // csc r, csc l, gem r, gem l

  typedef logic [55:0] link_data_t;  // four clusters, cluster 0 low
  typedef logic [31:0] link_word_t;  // one word on the wire
  typedef logic [7:0]  marker_t;     // frame marker byte

  typedef link_word_t [N_LINKS-1:0] link_word_vec_t;

  // ----------------------------------------
  // marker bytes
  // ----------------------------------------
  localparam marker_t MARK_BC0  = 8'hBC;  // start of orbit
  localparam marker_t MARK_OVF  = 8'h1C;  // cluster overflow
  localparam marker_t MARK_LAT  = 8'hFC;  // every 128 bx, latency check
  localparam marker_t MARK_DATA = 8'hF7;  // plain data frame

  // filler between frames
  localparam link_word_t IDLE_WORD = 32'h50BC50BC;

  // ----------------------------------------
  // link start-up
  // ----------------------------------------
  localparam int RESET_HOLD = 15;  // idle cycles after reset

  typedef logic [$clog2(RESET_HOLD+1)-1:0] rst_cnt_t;

endpackage

// ==== common/cluster_pkg.sv ====
package cluster_pkg;

  // ----------------------------------------
  // cluster inputs
  // ----------------------------------------
  localparam int N_CLUSTERS = 8;  // cluster words per bx

  typedef logic [13:0] cluster_t;  // one cluster word
  typedef logic [11:0] bxn_t;      // bunch crossing number
  typedef logic [N_CLUSTERS-1:0] cluster_vec_t;  // one flag per cluster

  // ----------------------------------------
  // captured bx
  // ----------------------------------------
  typedef struct packed {
    bxn_t bxn;
    logic bc0;       // orbit marker
    logic overflow;  // more clusters than inputs
  } bx_info_t;

  typedef struct packed {
    cluster_t [N_CLUSTERS-1:0] clusters;  // cluster 0 in the low bits
    bx_info_t                  bx;
  } capture_t;

  // bits 10:9 both set marks an empty slot
  function automatic logic cluster_valid(cluster_t c);
    return c[10:9] != 2'b11;
  endfunction

endpackage
